//--- Makefile
# Verilator build and run for the register alias table testbench

VERILATOR ?= verilator
TOP       ?= rat_tb
FILELIST  ?= rat_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only if the pass message shows up in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- rat_top.f
+incdir+testbench
rtl/rat_cfg_pkg.sv
rtl/rat_field_pkg.sv
rtl/rat_entry.sv
rtl/rat_read_stage.sv
rtl/rat_top.sv
testbench/rat_tb.sv

//--- rtl/rat_cfg_pkg.sv
// alias table geometry: register count, port counts and field widths
package rat_cfg_pkg;

  // architectural registers tracked by the table
  localparam int unsigned NUM_ARCH = 32;

  // read ports, rename write ports and retire ports
  localparam int unsigned NUM_READ = 3;
  localparam int unsigned NUM_WRITE = 3;
  localparam int unsigned NUM_RET = 3;

  // architectural register number
  localparam int unsigned ARCH_W = $clog2(NUM_ARCH);

  // reorder buffer tag of the newest producer
  localparam int unsigned TAG_W = 9;

  // one bit per function unit that may produce the value
  localparam int unsigned FUNIT_W = 10;

  // execution domain such as integer, fp or vector
  localparam int unsigned DOM_W = 2;

endpackage

//--- rtl/rat_entry.sv
// one alias table entry with rename write, tag retire and flush updates
`timescale 1ns/1ps

module rat_entry #(
  parameter int ENTRY_INDEX = 0
) (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic                                                 read_clk_en,
  input  logic [rat_cfg_pkg::NUM_WRITE-1:0]                    wr_wen,
  input  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_WRITE-1:0] wr_addr,
  input  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_WRITE-1:0]   wr_tag,
  input  rat_field_pkg::funit_t [rat_cfg_pkg::NUM_WRITE-1:0]     wr_funit,
  input  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_WRITE-1:0]    wr_dom,
  input  logic [rat_cfg_pkg::NUM_RET-1:0]                      ret_wen,
  input  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_RET-1:0]     ret_tag,
  input  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_RET-1:0]   ret_arch,
  input  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_RET-1:0]      ret_dom,
  input  logic                                                 retire_all,
  output rat_field_pkg::rob_tag_t                              tag,
  output rat_field_pkg::funit_t                                funit,
  output rat_field_pkg::domain_t                               dom,
  output logic                                                 retired
);

  localparam rat_field_pkg::arch_addr_t MY_ADDR = rat_field_pkg::arch_addr_t'(ENTRY_INDEX);

  // committed domain, restored into dom on a flush
  rat_field_pkg::domain_t cdom;

  // winning rename write
  logic                    wr_hit;
  rat_field_pkg::rob_tag_t wr_tag_sel;
  rat_field_pkg::funit_t   wr_funit_sel;
  rat_field_pkg::domain_t  wr_dom_sel;

  // tag retire against the stored producer
  logic ret_hit;

  // committed domain write by architectural number
  logic                   cdom_hit;
  rat_field_pkg::domain_t cdom_sel;

  // later ports overwrite earlier ones, so the highest port wins
  always_comb
  begin
    wr_hit = 1'b0;
    wr_tag_sel = tag;
    wr_funit_sel = funit;
    wr_dom_sel = dom;
    for (int p = 0; p < rat_cfg_pkg::NUM_WRITE; p++)
    begin
      if (wr_wen[p] && read_clk_en && wr_addr[p] == MY_ADDR)
      begin
        wr_hit = 1'b1;
        wr_tag_sel = wr_tag[p];
        wr_funit_sel = wr_funit[p];
        wr_dom_sel = wr_dom[p];
      end
    end
  end

  always_comb
  begin
    ret_hit = 1'b0;
    for (int p = 0; p < rat_cfg_pkg::NUM_RET; p++)
    begin
      if (ret_wen[p] && ret_tag[p] == tag)
      begin
        ret_hit = 1'b1;
      end
    end
  end

  always_comb
  begin
    cdom_hit = 1'b0;
    cdom_sel = cdom;
    for (int p = 0; p < rat_cfg_pkg::NUM_RET; p++)
    begin
      if (ret_wen[p] && ret_arch[p] == MY_ADDR)
      begin
        cdom_hit = 1'b1;
        cdom_sel = ret_dom[p];
      end
    end
  end

  // flush beats rename, rename beats a tag retire on the same entry
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tag <= rat_field_pkg::TAG_RESET;
      funit <= rat_field_pkg::FUNIT_RESET;
      dom <= rat_field_pkg::DOM_RESET;
      cdom <= rat_field_pkg::CDOM_RESET;
      retired <= 1'b1;
    end
    else
    begin
      if (retire_all)
      begin
        retired <= 1'b1;
        dom <= cdom;
      end
      else if (wr_hit)
      begin
        tag <= wr_tag_sel;
        funit <= wr_funit_sel;
        dom <= wr_dom_sel;
        retired <= 1'b0;
      end
      else if (ret_hit)
      begin
        retired <= 1'b1;
      end

      // committed domain keeps updating through a flush
      if (cdom_hit)
      begin
        cdom <= cdom_sel;
      end
    end
  end

endmodule

//--- rtl/rat_field_pkg.sv
// entry field types of the alias table and their reset values
package rat_field_pkg;

  typedef logic [rat_cfg_pkg::ARCH_W-1:0] arch_addr_t;

  typedef logic [rat_cfg_pkg::TAG_W-1:0] rob_tag_t;

  typedef logic [rat_cfg_pkg::FUNIT_W-1:0] funit_t;

  typedef logic [rat_cfg_pkg::DOM_W-1:0] domain_t;

  // all ones never matches a live rob tag after reset
  localparam rob_tag_t TAG_RESET = '1;

  // every unit except the top one may hold the reset value
  localparam funit_t FUNIT_RESET = funit_t'('h1FF);

  localparam domain_t DOM_RESET = domain_t'(3);

  // committed domain starts in domain 0
  localparam domain_t CDOM_RESET = domain_t'(0);

endpackage

//--- rtl/rat_read_stage.sv
// registered read addresses and per-port entry field multiplexers
`timescale 1ns/1ps

module rat_read_stage (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic                                                  read_clk_en,
  input  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_READ-1:0] rd_addr,
  input  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_ARCH-1:0]   ent_tag,
  input  rat_field_pkg::funit_t [rat_cfg_pkg::NUM_ARCH-1:0]     ent_funit,
  input  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_ARCH-1:0]    ent_dom,
  input  logic [rat_cfg_pkg::NUM_ARCH-1:0]                      ent_retired,
  output rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_READ-1:0]   rd_tag,
  output rat_field_pkg::funit_t [rat_cfg_pkg::NUM_READ-1:0]     rd_funit,
  output rat_field_pkg::domain_t [rat_cfg_pkg::NUM_READ-1:0]    rd_dom,
  output logic [rat_cfg_pkg::NUM_READ-1:0]                      rd_retired
);

  // captured address per read port
  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_READ-1:0] rd_addr_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_addr_q <= '0;
    end
    else if (read_clk_en)
    begin
      rd_addr_q <= rd_addr;
    end
  end

  // outputs follow the live entry state, so a held address sees later updates
  always_comb
  begin
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
    begin
      rd_tag[p] = ent_tag[rd_addr_q[p]];
      rd_funit[p] = ent_funit[rd_addr_q[p]];
      rd_dom[p] = ent_dom[rd_addr_q[p]];
      rd_retired[p] = ent_retired[rd_addr_q[p]];
    end
  end

endmodule

//--- rtl/rat_top.sv
// register alias table top level built from generated entries and one read stage
`timescale 1ns/1ps

module rat_top (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic                                                   read_clk_en,

  // rename writes
  input  logic [rat_cfg_pkg::NUM_WRITE-1:0]                      wr_wen,
  input  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_WRITE-1:0] wr_addr,
  input  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_WRITE-1:0]   wr_tag,
  input  rat_field_pkg::funit_t [rat_cfg_pkg::NUM_WRITE-1:0]     wr_funit,
  input  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_WRITE-1:0]    wr_dom,

  // retire by tag, plus committed domain by architectural number
  input  logic [rat_cfg_pkg::NUM_RET-1:0]                        ret_wen,
  input  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_RET-1:0]     ret_tag,
  input  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_RET-1:0]   ret_arch,
  input  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_RET-1:0]      ret_dom,

  // pipeline flush
  input  logic                                                   retire_all,

  // reads
  input  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_READ-1:0]  rd_addr,
  output rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_READ-1:0]    rd_tag,
  output logic [rat_cfg_pkg::NUM_READ-1:0]                       rd_retired,
  output rat_field_pkg::funit_t [rat_cfg_pkg::NUM_READ-1:0]      rd_funit,
  output rat_field_pkg::domain_t [rat_cfg_pkg::NUM_READ-1:0]     rd_dom
);

  // every entry's fields, indexed by architectural register
  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_ARCH-1:0] ent_tag;
  rat_field_pkg::funit_t [rat_cfg_pkg::NUM_ARCH-1:0]   ent_funit;
  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_ARCH-1:0]  ent_dom;
  logic [rat_cfg_pkg::NUM_ARCH-1:0]                    ent_retired;

  for (genvar k = 0; k < rat_cfg_pkg::NUM_ARCH; k++)
  begin : g_entry
    rat_entry #(
      .ENTRY_INDEX(k)
    ) entry_i (
      .clk         (clk),
      .rst         (rst),
      .read_clk_en (read_clk_en),
      .wr_wen      (wr_wen),
      .wr_addr     (wr_addr),
      .wr_tag      (wr_tag),
      .wr_funit    (wr_funit),
      .wr_dom      (wr_dom),
      .ret_wen     (ret_wen),
      .ret_tag     (ret_tag),
      .ret_arch    (ret_arch),
      .ret_dom     (ret_dom),
      .retire_all  (retire_all),
      .tag         (ent_tag[k]),
      .funit       (ent_funit[k]),
      .dom         (ent_dom[k]),
      .retired     (ent_retired[k])
    );
  end

  rat_read_stage read_stage_i (
    .clk         (clk),
    .rst         (rst),
    .read_clk_en (read_clk_en),
    .rd_addr     (rd_addr),
    .ent_tag     (ent_tag),
    .ent_funit   (ent_funit),
    .ent_dom     (ent_dom),
    .ent_retired (ent_retired),
    .rd_tag      (rd_tag),
    .rd_funit    (rd_funit),
    .rd_dom      (rd_dom),
    .rd_retired  (rd_retired)
  );

endmodule

//--- testbench/rat_model.svh
// reference model of the alias table: field arrays, captured read addresses, clock step
`ifndef RAT_MODEL_SVH
`define RAT_MODEL_SVH

rat_field_pkg::rob_tag_t   model_tag [rat_cfg_pkg::NUM_ARCH];
rat_field_pkg::funit_t     model_funit [rat_cfg_pkg::NUM_ARCH];
rat_field_pkg::domain_t    model_dom [rat_cfg_pkg::NUM_ARCH];
rat_field_pkg::domain_t    model_cdom [rat_cfg_pkg::NUM_ARCH];
logic                      model_retired [rat_cfg_pkg::NUM_ARCH];
rat_field_pkg::arch_addr_t model_rd_addr [rat_cfg_pkg::NUM_READ];

// advance the model by one rising edge, using the inputs the DUT sees at that edge
task automatic model_step();
  int                     win_wr;
  int                     win_ret;
  logic                   tag_hit;
  rat_field_pkg::domain_t old_cdom;
  if (rst)
  begin
    for (int k = 0; k < rat_cfg_pkg::NUM_ARCH; k++)
    begin
      model_tag[k] = rat_field_pkg::TAG_RESET;
      model_funit[k] = rat_field_pkg::FUNIT_RESET;
      model_dom[k] = rat_field_pkg::DOM_RESET;
      model_cdom[k] = rat_field_pkg::CDOM_RESET;
      model_retired[k] = 1'b1;
    end
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
    begin
      model_rd_addr[p] = '0;
    end
  end
  else
  begin
    for (int k = 0; k < rat_cfg_pkg::NUM_ARCH; k++)
    begin
      old_cdom = model_cdom[k];
      // search from the top port down, first match is the winner
      win_wr = -1;
      for (int p = rat_cfg_pkg::NUM_WRITE - 1; p >= 0; p--)
      begin
        if (win_wr < 0 && read_clk_en && wr_wen[p] &&
            wr_addr[p] == rat_field_pkg::arch_addr_t'(k))
        begin
          win_wr = p;
        end
      end
      tag_hit = 1'b0;
      for (int p = 0; p < rat_cfg_pkg::NUM_RET; p++)
      begin
        if (ret_wen[p] && ret_tag[p] == model_tag[k])
        begin
          tag_hit = 1'b1;
        end
      end
      win_ret = -1;
      for (int p = rat_cfg_pkg::NUM_RET - 1; p >= 0; p--)
      begin
        if (win_ret < 0 && ret_wen[p] && ret_arch[p] == rat_field_pkg::arch_addr_t'(k))
        begin
          win_ret = p;
        end
      end
      if (retire_all)
      begin
        model_retired[k] = 1'b1;
        model_dom[k] = old_cdom;
      end
      else if (win_wr >= 0)
      begin
        model_tag[k] = wr_tag[win_wr];
        model_funit[k] = wr_funit[win_wr];
        model_dom[k] = wr_dom[win_wr];
        model_retired[k] = 1'b0;
      end
      else if (tag_hit)
      begin
        model_retired[k] = 1'b1;
      end
      if (win_ret >= 0)
      begin
        model_cdom[k] = ret_dom[win_ret];
      end
    end
    if (read_clk_en)
    begin
      for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
      begin
        model_rd_addr[p] = rd_addr[p];
      end
    end
  end
endtask

`endif

//--- testbench/rat_tb.sv
// testbench for rat_top with directed cases and a random run checked against a model
`timescale 1ns/1ps

module rat_tb;

  localparam int RANDOM_CYCLES = 3000;
  localparam int MAX_CYCLES = 5000;
  localparam int RESET_TIMEOUT = 16;

  logic clk;
  logic rst;
  logic read_clk_en;
  logic retire_all;

  logic [rat_cfg_pkg::NUM_WRITE-1:0]                      wr_wen;
  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_WRITE-1:0] wr_addr;
  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_WRITE-1:0]   wr_tag;
  rat_field_pkg::funit_t [rat_cfg_pkg::NUM_WRITE-1:0]     wr_funit;
  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_WRITE-1:0]    wr_dom;

  logic [rat_cfg_pkg::NUM_RET-1:0]                        ret_wen;
  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_RET-1:0]     ret_tag;
  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_RET-1:0]   ret_arch;
  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_RET-1:0]      ret_dom;

  rat_field_pkg::arch_addr_t [rat_cfg_pkg::NUM_READ-1:0]  rd_addr;
  rat_field_pkg::rob_tag_t [rat_cfg_pkg::NUM_READ-1:0]    rd_tag;
  logic [rat_cfg_pkg::NUM_READ-1:0]                       rd_retired;
  rat_field_pkg::funit_t [rat_cfg_pkg::NUM_READ-1:0]      rd_funit;
  rat_field_pkg::domain_t [rat_cfg_pkg::NUM_READ-1:0]     rd_dom;

  integer seed = 58;

  `include "rat_model.svh"

  rat_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .read_clk_en (read_clk_en),
    .wr_wen      (wr_wen),
    .wr_addr     (wr_addr),
    .wr_tag      (wr_tag),
    .wr_funit    (wr_funit),
    .wr_dom      (wr_dom),
    .ret_wen     (ret_wen),
    .ret_tag     (ret_tag),
    .ret_arch    (ret_arch),
    .ret_dom     (ret_dom),
    .retire_all  (retire_all),
    .rd_addr     (rd_addr),
    .rd_tag      (rd_tag),
    .rd_retired  (rd_retired),
    .rd_funit    (rd_funit),
    .rd_dom      (rd_dom)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // global limit on run length
  initial
  begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "simulation timeout");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // about half the retire tags hit a live mapping
  function automatic rat_field_pkg::rob_tag_t pick_retire_tag();
    if (rand_below(2) == 1)
    begin
      return model_tag[rand_below(rat_cfg_pkg::NUM_ARCH)];
    end
    else
    begin
      return rat_field_pkg::rob_tag_t'(rand_below(512));
    end
  endfunction

  task automatic tick();
    @(posedge clk);
    model_step();
  endtask

  task automatic drive_idle();
    read_clk_en <= 1'b1;
    retire_all <= 1'b0;
    wr_wen <= '0;
    ret_wen <= '0;
  endtask

  task automatic drive_rd_all(input rat_field_pkg::arch_addr_t a);
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
    begin
      rd_addr[p] <= a;
    end
  endtask

  task automatic drive_random();
    read_clk_en <= rand_below(4) != 0;
    retire_all <= rand_below(32) == 0;
    for (int p = 0; p < rat_cfg_pkg::NUM_WRITE; p++)
    begin
      wr_wen[p] <= rand_below(2) == 1;
      // a narrow address range makes port collisions common
      if (rand_below(2) == 1)
        wr_addr[p] <= rat_field_pkg::arch_addr_t'(rand_below(4));
      else
        wr_addr[p] <= rat_field_pkg::arch_addr_t'(rand_below(rat_cfg_pkg::NUM_ARCH));
      wr_tag[p] <= rat_field_pkg::rob_tag_t'(rand_below(512));
      wr_funit[p] <= rat_field_pkg::funit_t'(rand_below(1024));
      wr_dom[p] <= rat_field_pkg::domain_t'(rand_below(4));
    end
    for (int p = 0; p < rat_cfg_pkg::NUM_RET; p++)
    begin
      ret_wen[p] <= rand_below(2) == 1;
      ret_tag[p] <= pick_retire_tag();
      ret_arch[p] <= rat_field_pkg::arch_addr_t'(rand_below(rat_cfg_pkg::NUM_ARCH));
      ret_dom[p] <= rat_field_pkg::domain_t'(rand_below(4));
    end
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
    begin
      rd_addr[p] <= rat_field_pkg::arch_addr_t'(rand_below(rat_cfg_pkg::NUM_ARCH));
    end
  endtask

  // outputs are sampled mid-cycle, away from the driving edge
  task automatic compare_reads(input string name);
    rat_field_pkg::arch_addr_t a;
    @(negedge clk);
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
    begin
      a = model_rd_addr[p];
      check_value($sformatf("%s tag port %0d", name, p), 32'(model_tag[a]), 32'(rd_tag[p]));
      check_value($sformatf("%s funit port %0d", name, p), 32'(model_funit[a]),
                  32'(rd_funit[p]));
      check_value($sformatf("%s dom port %0d", name, p), 32'(model_dom[a]), 32'(rd_dom[p]));
      check_value($sformatf("%s retired port %0d", name, p), 32'(model_retired[a]),
                  32'(rd_retired[p]));
    end
  endtask

  task automatic check_reset_values();
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
    begin
      check_value("reset tag", 32'h1FF, 32'(rd_tag[p]));
      check_value("reset funit", 32'h1FF, 32'(rd_funit[p]));
      check_value("reset dom", 32'd3, 32'(rd_dom[p]));
      check_value("reset retired", 32'd1, 32'(rd_retired[p]));
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst && waited < RESET_TIMEOUT)
    begin
      tick();
      waited++;
    end
    if (rst)
    begin
      $display("reset was still asserted after %0d cycles", RESET_TIMEOUT);
      $display("CHECKS FAILED");
      $fatal(1, "reset wait timeout");
    end
  endtask

  initial
  begin
    rst <= 1'b1;
    read_clk_en <= 1'b0;
    retire_all <= 1'b0;
    wr_wen <= '0;
    wr_addr <= '0;
    wr_tag <= '0;
    wr_funit <= '0;
    wr_dom <= '0;
    ret_wen <= '0;
    ret_tag <= '0;
    ret_arch <= '0;
    ret_dom <= '0;
    rd_addr <= '0;

    repeat (4) tick();
    rst <= 1'b0;
    drive_idle();
    wait_reset_release();

    // read the reset contents three addresses per capture until all 32 are seen
    for (int i = 0; i <= 11; i++)
    begin
      if (i > 0)
        tick();
      drive_idle();
      for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
      begin
        rd_addr[p] <= rat_field_pkg::arch_addr_t'((3 * i + p) % 32);
      end
      compare_reads("reset read");
      check_reset_values();
    end

    // three ports rename register 5 and port 2 wins
    tick();
    drive_idle();
    wr_wen <= 3'b111;
    wr_addr[0] <= 5'd5;
    wr_addr[1] <= 5'd5;
    wr_addr[2] <= 5'd5;
    wr_tag[0] <= 9'h011;
    wr_tag[1] <= 9'h022;
    wr_tag[2] <= 9'h033;
    wr_funit[0] <= 10'h001;
    wr_funit[2] <= 10'h2A5;
    wr_dom[0] <= 2'd0;
    wr_dom[2] <= 2'd1;
    drive_rd_all(5'd5);
    compare_reads("rename issue");
    tick();
    drive_idle();
    compare_reads("rename write");
    check_value("rename tag", 32'h033, 32'(rd_tag[0]));
    check_value("rename funit", 32'h2A5, 32'(rd_funit[1]));
    check_value("rename dom", 32'd1, 32'(rd_dom[2]));
    check_value("rename retired", 32'd0, 32'(rd_retired[0]));

    // a gated cycle drops the write and keeps the old read address
    tick();
    drive_idle();
    read_clk_en <= 1'b0;
    wr_wen[0] <= 1'b1;
    wr_tag[0] <= 9'h0AA;
    drive_rd_all(5'd9);
    compare_reads("gated issue");
    tick();
    drive_idle();
    read_clk_en <= 1'b0;
    ret_wen[0] <= 1'b1;
    ret_tag[0] <= 9'h033;
    ret_arch[0] <= 5'd5;
    ret_dom[0] <= 2'd2;
    compare_reads("gated write");
    check_value("gated tag", 32'h033, 32'(rd_tag[0]));
    check_value("gated retired", 32'd0, 32'(rd_retired[0]));
    tick();
    drive_idle();
    compare_reads("held retire");
    check_value("held tag", 32'h033, 32'(rd_tag[0]));
    check_value("held retired", 32'd1, 32'(rd_retired[0]));

    // rename and retire of the same entry in one cycle
    tick();
    drive_idle();
    wr_wen[0] <= 1'b1;
    wr_addr[0] <= 5'd6;
    wr_tag[0] <= 9'h044;
    drive_rd_all(5'd6);
    compare_reads("rename six");
    tick();
    drive_idle();
    wr_wen[0] <= 1'b1;
    wr_tag[0] <= 9'h055;
    ret_wen[1] <= 1'b1;
    ret_tag[1] <= 9'h044;
    ret_arch[1] <= 5'd6;
    ret_dom[1] <= 2'd1;
    compare_reads("retire race issue");
    check_value("race tag before", 32'h044, 32'(rd_tag[1]));
    tick();
    drive_idle();
    ret_wen[2] <= 1'b1;
    ret_tag[2] <= 9'h055;
    ret_arch[2] <= 5'd6;
    ret_dom[2] <= 2'd3;
    compare_reads("retire race");
    check_value("race tag", 32'h055, 32'(rd_tag[1]));
    check_value("race retired", 32'd0, 32'(rd_retired[1]));
    tick();
    drive_idle();
    compare_reads("tag retire");
    check_value("tag retire retired", 32'd1, 32'(rd_retired[1]));

    // write committed domains and then flush with a write that must be dropped
    tick();
    drive_idle();
    ret_wen <= 3'b111;
    ret_tag[0] <= 9'h0FF;
    ret_tag[1] <= 9'h0FF;
    ret_tag[2] <= 9'h0FF;
    ret_arch[0] <= 5'd5;
    ret_arch[1] <= 5'd6;
    ret_arch[2] <= 5'd6;
    ret_dom[0] <= 2'd2;
    ret_dom[1] <= 2'd1;
    ret_dom[2] <= 2'd3;
    rd_addr[0] <= 5'd5;
    rd_addr[1] <= 5'd6;
    rd_addr[2] <= 5'd7;
    compare_reads("commit domains");
    tick();
    drive_idle();
    retire_all <= 1'b1;
    wr_wen[0] <= 1'b1;
    wr_addr[0] <= 5'd5;
    wr_tag[0] <= 9'h1AB;
    compare_reads("flush issue");
    tick();
    drive_idle();
    compare_reads("flush");
    check_value("flush tag", 32'h033, 32'(rd_tag[0]));
    check_value("flush dom five", 32'd2, 32'(rd_dom[0]));
    check_value("flush retired five", 32'd1, 32'(rd_retired[0]));
    check_value("flush dom six", 32'd3, 32'(rd_dom[1]));
    check_value("flush retired six", 32'd1, 32'(rd_retired[1]));

    for (int n = 0; n < RANDOM_CYCLES; n++)
    begin
      tick();
      drive_random();
      compare_reads("random");
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
